// ==== common/kbd_pkg.sv ====
package kbd_pkg;

	////////////////////////////////////////
	// Timing and framing constants
	////////////////////////////////////////

	// Equal ps2_clk samples needed before the filtered level moves
	localparam int FILTER_LEN = 8;
	// About 100 us at 28 MHz without a falling edge drops a partial frame
	localparam int WATCHDOG_CYCLES = 2900;
	localparam int WATCHDOG_W = $clog2(WATCHDOG_CYCLES + 1);
	// Start, 8 data, odd parity, stop
	localparam int FRAME_BITS = 11;
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

	// Scan-code set 2 prefix bytes
	localparam logic [7:0] CODE_EXTENDED = 8'hE0;
	localparam logic [7:0] CODE_BREAK = 8'hF0;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// One decoded key transition
	typedef struct packed {
		logic       extended;
		logic       released;
		logic [7:0] code;
	} key_event_t;

	// Prefix bytes seen so far in the current sequence
	typedef enum logic [1:0] {
		IDLE,
		EXT,
		BRK,
		EXT_BRK
	} dec_state_t;

	// Column and row of a key in the 8x8 matrix
	typedef struct packed {
		logic       valid;
		logic [2:0] col;
		logic [2:0] row;
	} matrix_pos_t;

	////////////////////////////////////////
	// Scan code to matrix position
	////////////////////////////////////////

	// Layout follows the C64 matrix, arrows take spare column 0 slots
	function automatic matrix_pos_t key_position(input key_event_t ev);
		matrix_pos_t pos;
		pos = '0;
		if (!ev.extended)
		begin
			case (ev.code)
				// Column 0
				8'h5A: pos = '{1'b1, 3'd0, 3'd1};
				// Column 1: 3 W A 4 Z S E, left shift
				8'h26: pos = '{1'b1, 3'd1, 3'd0};
				8'h1D: pos = '{1'b1, 3'd1, 3'd1};
				8'h1C: pos = '{1'b1, 3'd1, 3'd2};
				8'h25: pos = '{1'b1, 3'd1, 3'd3};
				8'h1A: pos = '{1'b1, 3'd1, 3'd4};
				8'h1B: pos = '{1'b1, 3'd1, 3'd5};
				8'h24: pos = '{1'b1, 3'd1, 3'd6};
				8'h12: pos = '{1'b1, 3'd1, 3'd7};
				// Column 2: 5 R D 6 C F T X
				8'h2E: pos = '{1'b1, 3'd2, 3'd0};
				8'h2D: pos = '{1'b1, 3'd2, 3'd1};
				8'h23: pos = '{1'b1, 3'd2, 3'd2};
				8'h36: pos = '{1'b1, 3'd2, 3'd3};
				8'h21: pos = '{1'b1, 3'd2, 3'd4};
				8'h2B: pos = '{1'b1, 3'd2, 3'd5};
				8'h2C: pos = '{1'b1, 3'd2, 3'd6};
				8'h22: pos = '{1'b1, 3'd2, 3'd7};
				// Column 3: 7 Y G 8 B H U V
				8'h3D: pos = '{1'b1, 3'd3, 3'd0};
				8'h35: pos = '{1'b1, 3'd3, 3'd1};
				8'h34: pos = '{1'b1, 3'd3, 3'd2};
				8'h3E: pos = '{1'b1, 3'd3, 3'd3};
				8'h32: pos = '{1'b1, 3'd3, 3'd4};
				8'h33: pos = '{1'b1, 3'd3, 3'd5};
				8'h3C: pos = '{1'b1, 3'd3, 3'd6};
				8'h2A: pos = '{1'b1, 3'd3, 3'd7};
				// Column 4: 9 I J 0 M K O N
				8'h46: pos = '{1'b1, 3'd4, 3'd0};
				8'h43: pos = '{1'b1, 3'd4, 3'd1};
				8'h3B: pos = '{1'b1, 3'd4, 3'd2};
				8'h45: pos = '{1'b1, 3'd4, 3'd3};
				8'h3A: pos = '{1'b1, 3'd4, 3'd4};
				8'h42: pos = '{1'b1, 3'd4, 3'd5};
				8'h44: pos = '{1'b1, 3'd4, 3'd6};
				8'h31: pos = '{1'b1, 3'd4, 3'd7};
				// Columns 5 and 6: P L, right shift
				8'h4D: pos = '{1'b1, 3'd5, 3'd1};
				8'h4B: pos = '{1'b1, 3'd5, 3'd2};
				8'h59: pos = '{1'b1, 3'd6, 3'd4};
				// Column 7: 1 2 space Q
				8'h16: pos = '{1'b1, 3'd7, 3'd0};
				8'h1E: pos = '{1'b1, 3'd7, 3'd3};
				8'h29: pos = '{1'b1, 3'd7, 3'd4};
				8'h15: pos = '{1'b1, 3'd7, 3'd6};
				default: pos = '0;
			endcase
		end
		else
		begin
			// Only the cursor block is mapped among E0 codes
			case (ev.code)
				8'h74: pos = '{1'b1, 3'd0, 3'd2};
				8'h75: pos = '{1'b1, 3'd0, 3'd3};
				8'h6B: pos = '{1'b1, 3'd0, 3'd4};
				8'h72: pos = '{1'b1, 3'd0, 3'd7};
				default: pos = '0;
			endcase
		end
		return pos;
	endfunction

endpackage

// ==== ps2/ps2_receiver.sv ====
`timescale 1ns/1ns

module ps2_receiver (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic       rx_done,
	output logic [7:0] rx_byte,
	output logic       frame_error
);
	import kbd_pkg::*;

	// Clock line filter and edge detect
	logic [FILTER_LEN-1:0]  clk_filter;
	logic                   clk_filt;
	logic                   clk_filt_d;
	logic                   fall;
	// Two-stage sync on the data line
	logic [1:0]             data_sync;
	// Frame assembly
	logic [FRAME_BITS-1:0]  shift_reg;
	logic [FRAME_BITS-1:0]  frame_next;
	logic [FRAME_CNT_W-1:0] bit_cnt;
	logic                   last_bit;
	logic                   frame_ok;
	logic [WATCHDOG_W-1:0]  watchdog;

	////////////////////////////////////////
	// Glitch filter
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			// Idle PS/2 lines sit high
			clk_filter <= '1;
			clk_filt   <= 1'b1;
			clk_filt_d <= 1'b1;
			data_sync  <= 2'b11;
		end
		else
		begin
			clk_filter <= {clk_filter[FILTER_LEN-2:0], ps2_clk};
			// Level moves only after a full run of equal samples
			if (clk_filter == '0)
				clk_filt <= 1'b0;
			else if (clk_filter == '1)
				clk_filt <= 1'b1;
			clk_filt_d <= clk_filt;
			data_sync  <= {data_sync[0], ps2_data};
		end
	end

	assign fall = clk_filt_d & ~clk_filt;

	////////////////////////////////////////
	// Frame check
	////////////////////////////////////////

	// LSB first, so new bits enter at the top
	assign frame_next = {data_sync[1], shift_reg[FRAME_BITS-1:1]};
	assign last_bit   = (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1));
	// Start low, stop high, odd parity over data and parity bit
	assign frame_ok   = ~frame_next[0] & frame_next[FRAME_BITS-1] & (^frame_next[9:1]);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bit_cnt     <= '0;
			watchdog    <= WATCHDOG_W'(WATCHDOG_CYCLES);
			rx_done     <= 1'b0;
			frame_error <= 1'b0;
		end
		else
		begin
			rx_done     <= 1'b0;
			frame_error <= 1'b0;
			if (fall)
			begin
				// Every edge restarts the inactivity timeout
				watchdog <= WATCHDOG_W'(WATCHDOG_CYCLES);
				if (last_bit)
				begin
					bit_cnt     <= '0;
					rx_done     <= frame_ok;
					frame_error <= ~frame_ok;
				end
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
			else if (watchdog == '0)
				// Line went quiet mid-frame, drop what we have
				bit_cnt <= '0;
			else
				watchdog <= watchdog - 1'b1;
		end
	end

	// Shift register and received byte
	always_ff @(posedge clk)
	begin
		if (fall)
			shift_reg <= frame_next;
		if (fall && last_bit && frame_ok)
			rx_byte <= frame_next[8:1];
	end

endmodule

// ==== ps2/ps2_scancode_decoder.sv ====
`timescale 1ns/1ns

module ps2_scancode_decoder (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               rx_done,
	input  logic [7:0]         rx_byte,
	input  logic               frame_error,
	output logic               key_valid,
	output kbd_pkg::key_event_t key
);
	import kbd_pkg::*;

	dec_state_t state;
	dec_state_t state_next;
	logic       is_prefix;
	logic       ext_flag;
	logic       rel_flag;

	////////////////////////////////////////
	// Prefix tracking
	////////////////////////////////////////

	assign is_prefix = (rx_byte == CODE_EXTENDED) || (rx_byte == CODE_BREAK);
	// Flags of the pending sequence
	assign ext_flag  = (state == EXT) || (state == EXT_BRK);
	assign rel_flag  = (state == BRK) || (state == EXT_BRK);

	always_comb
	begin
		state_next = state;
		if (frame_error)
			// A lost byte may have been a prefix, start over
			state_next = IDLE;
		else if (rx_done)
		begin
			if (rx_byte == CODE_EXTENDED)
				state_next = EXT;
			else if (rx_byte == CODE_BREAK)
				state_next = ext_flag ? EXT_BRK : BRK;
			else
				// Final code byte closes the sequence
				state_next = IDLE;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= IDLE;
			key_valid <= 1'b0;
		end
		else
		begin
			state     <= state_next;
			// Strobe only for a code byte, never a prefix
			key_valid <= rx_done & ~is_prefix;
		end
	end

	////////////////////////////////////////
	// Event payload
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rx_done && !is_prefix)
		begin
			key.extended <= ext_flag;
			key.released <= rel_flag;
			key.code     <= rx_byte;
		end
	end

endmodule

// ==== hw/key_matrix.sv ====
`timescale 1ns/1ns

module key_matrix (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                key_valid,
	input  kbd_pkg::key_event_t key,
	input  logic [7:0]          col_sel,
	output logic [7:0]          row_out
);
	import kbd_pkg::*;

	// Pressed flags, indexed column then row
	logic [7:0][7:0] pressed;
	logic [7:0]      rows_low;
	matrix_pos_t     pos;

	////////////////////////////////////////
	// Key state update
	////////////////////////////////////////

	// Table lookup for the incoming event
	assign pos = key_position(key);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			// All keys up after reset
			pressed <= '0;
		else if (key_valid && pos.valid)
			// Make sets, break clears
			pressed[pos.col][pos.row] <= ~key.released;
	end

	////////////////////////////////////////
	// Column scan
	////////////////////////////////////////

	always_comb
	begin
		rows_low = '0;
		for (int c = 0; c < 8; c++)
		begin
			// Low select bit enables the column
			if (!col_sel[c])
				rows_low = rows_low | pressed[c];
		end
	end

	// Rows read active low, union of all selected columns
	assign row_out = ~rows_low;

endmodule

// ==== hw/kbd_top.sv ====
`timescale 1ns/1ns

module kbd_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	input  logic [7:0]          col_sel,
	output logic [7:0]          row_out,
	output logic                key_valid,
	output kbd_pkg::key_event_t key,
	output logic                frame_error
);

	// Receiver to decoder byte strobe
	logic       rx_done;
	logic [7:0] rx_byte;

	////////////////////////////////////////
	// PS/2 front end
	////////////////////////////////////////

	ps2_receiver i_receiver (
		.clk         (clk),
		.rst_n       (rst_n),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.rx_done     (rx_done),
		.rx_byte     (rx_byte),
		.frame_error (frame_error)
	);

	// Folds E0 and F0 into events
	ps2_scancode_decoder i_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_done     (rx_done),
		.rx_byte     (rx_byte),
		.frame_error (frame_error),
		.key_valid   (key_valid),
		.key         (key)
	);

	////////////////////////////////////////
	// CPU side matrix
	////////////////////////////////////////

	key_matrix i_matrix (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_valid (key_valid),
		.key       (key),
		.col_sel   (col_sel),
		.row_out   (row_out)
	);

endmodule

// ==== test/kbd_assert.sv ====
`timescale 1ns/1ns

module kbd_assert (
	input logic       clk,
	input logic       rst_n,
	input logic       rx_done,
	input logic [7:0] rx_byte,
	input logic       frame_error,
	input logic       key_valid,
	input logic [7:0] row_out
);
	import kbd_pkg::*;

	////////////////////////////////////////
	// Receiver strobes
	////////////////////////////////////////

	// Good and bad frame are exclusive
	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(rx_done && frame_error))
	else
		$error("rx_done and frame_error high in the same cycle");

	// One-cycle pulses only
	a_rx_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rx_done |=> !rx_done)
	else
		$error("rx_done held longer than one cycle");

	a_ferr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		frame_error |=> !frame_error)
	else
		$error("frame_error held longer than one cycle");

	////////////////////////////////////////
	// Decoder timing
	////////////////////////////////////////

	// Code byte gives an event one cycle later
	a_key_follows: assert property (@(posedge clk) disable iff (!rst_n)
		(rx_done && rx_byte != CODE_EXTENDED && rx_byte != CODE_BREAK) |=> key_valid)
	else
		$error("key_valid missing one cycle after a code byte");

	// No event without a byte the cycle before
	a_key_cause: assert property (@(posedge clk) disable iff (!rst_n)
		key_valid |-> $past(rx_done))
	else
		$error("key_valid without rx_done one cycle earlier");

	a_key_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		key_valid |=> !key_valid)
	else
		$error("key_valid held longer than one cycle");

	////////////////////////////////////////
	// Reset state
	////////////////////////////////////////

	// Quiet outputs and released keys while in reset
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> (!rx_done && !frame_error && !key_valid && row_out == 8'hFF))
	else
		$error("outputs active or keys pressed during reset");

endmodule

// ==== test/tb_kbd.sv ====
`timescale 1ns/1ns

module tb_kbd;
	import kbd_pkg::*;

	localparam int DRV = 1;
	localparam int HALF = 40;
	// Rough upper bound on frames sent, sizes the run watchdog
	localparam int NUM_FRAMES = 80;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * (FRAME_BITS * 2 * HALF + 400)
		+ 2 * WATCHDOG_CYCLES + 5000;
	// A strobe is awaited while its frame is still being sent
	localparam int STROBE_WAIT = FRAME_BITS * 2 * HALF + 100;

	logic       clk;
	logic       rst_n;
	logic       ps2_clk;
	logic       ps2_data;
	logic [7:0] col_sel;
	logic [7:0] row_out;
	logic       key_valid;
	key_event_t key;
	logic       frame_error;

	// Expectations and reference key model
	logic       expect_event;
	logic       expect_ferr;
	key_event_t exp_key;
	logic [7:0] model_pressed [8];
	matrix_pos_t model_pos;

	kbd_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.col_sel     (col_sel),
		.row_out     (row_out),
		.key_valid   (key_valid),
		.key         (key),
		.frame_error (frame_error)
	);

	bind kbd_top kbd_assert i_assert (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_done     (rx_done),
		.rx_byte     (rx_byte),
		.frame_error (frame_error),
		.key_valid   (key_valid),
		.row_out     (row_out)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic value_fail(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("Fail %s expected %h got %h", name, exp, got);
		abort_run();
	endtask

	task automatic plain_fail(input string msg);
		$display("%s", msg);
		abort_run();
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Union of pressed rows over selected columns, active low
	function automatic logic [7:0] predict_rows(input logic [7:0] sel);
		logic [7:0] rows;
		rows = '0;
		for (int c = 0; c < 8; c++)
			if (!sel[c])
				rows = rows | model_pressed[c];
		return ~rows;
	endfunction

	// Model follows the expected event, in step with the matrix
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			// All keys up while in reset
			for (int c = 0; c < 8; c++)
				model_pressed[c] <= '0;
		end
		else if (key_valid)
		begin
			model_pos = key_position(exp_key);
			if (model_pos.valid)
				model_pressed[model_pos.col][model_pos.row] <= ~exp_key.released;
		end
	end

	a_key_expected: assert property (@(posedge clk) disable iff (!rst_n)
		key_valid |-> expect_event)
	else
		plain_fail("key event appeared where none was expected");

	a_key_value: assert property (@(posedge clk) disable iff (!rst_n)
		key_valid |-> key == exp_key)
	else
		value_fail("key", 32'(exp_key), 32'(key));

	a_ferr_expected: assert property (@(posedge clk) disable iff (!rst_n)
		frame_error |-> expect_ferr)
	else
		plain_fail("frame error pulse appeared where none was expected");

	a_rows: assert property (@(posedge clk) disable iff (!rst_n)
		row_out == predict_rows(col_sel))
	else
		value_fail("row_out", 32'(predict_rows(col_sel)), 32'(row_out));

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#DRV;
	endtask

	// Half a PS/2 clock period, optionally with a short spike
	task automatic half_phase(input logic level, input bit glitch);
		if (glitch)
		begin
			step(15);
			ps2_clk = ~level;
			step(3);
			ps2_clk = level;
			step(HALF - 18);
		end
		else
			step(HALF);
	endtask

	task automatic send_frame(input logic [7:0] data, input bit bad_parity, input bit bad_start,
		input bit bad_stop, input int nbits, input bit glitch);
		logic [10:0] frame;
		frame[0]   = bad_start;
		frame[8:1] = data;
		// Odd parity over data and parity bit
		frame[9]   = ~(^data) ^ bad_parity;
		frame[10]  = ~bad_stop;
		for (int i = 0; i < nbits; i++)
		begin
			ps2_data = frame[i];
			half_phase(1'b1, glitch);
			ps2_clk = 1'b0;
			half_phase(1'b0, glitch);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic gap();
		step(50 + $urandom_range(250));
	endtask

	task automatic wait_event();
		bit seen;
		seen = 0;
		for (int n = 0; n < STROBE_WAIT && !seen; n++)
		begin
			step(1);
			seen = key_valid;
		end
		if (!seen)
			plain_fail("no key event arrived after the code byte");
		else
		begin
			// Expectation stays open through the edge that samples the strobe
			step(1);
			expect_event = 1'b0;
		end
	endtask

	task automatic wait_ferr();
		bit seen;
		seen = 0;
		for (int n = 0; n < STROBE_WAIT && !seen; n++)
		begin
			step(1);
			seen = frame_error;
		end
		if (!seen)
			plain_fail("no frame error pulse after a bad frame");
		else
		begin
			step(1);
			expect_ferr = 1'b0;
		end
	endtask

	// Optional prefixes, then the code byte with its expected event
	task automatic send_key(input bit ext, input bit rel, input logic [7:0] code, input bit glitch);
		if (ext)
		begin
			send_frame(CODE_EXTENDED, 0, 0, 0, FRAME_BITS, glitch);
			gap();
		end
		if (rel)
		begin
			send_frame(CODE_BREAK, 0, 0, 0, FRAME_BITS, glitch);
			gap();
		end
		exp_key      = '{ext, rel, code};
		expect_event = 1'b1;
		// Event strobe fires before the last clock phase ends
		fork
			send_frame(code, 0, 0, 0, FRAME_BITS, glitch);
			wait_event();
		join
		gap();
	endtask

	// Pending break, bad frame, then the code must come as a make
	task automatic error_frame(input bit bad_parity, input bit bad_start, input bit bad_stop);
		send_frame(CODE_BREAK, 0, 0, 0, FRAME_BITS, 0);
		gap();
		expect_ferr = 1'b1;
		fork
			send_frame(8'h1C, bad_parity, bad_start, bad_stop, FRAME_BITS, 0);
			wait_ferr();
		join
		gap();
		send_key(0, 0, 8'h1C, 0);
	endtask

	task automatic scan_all();
		for (int c = 0; c < 8; c++)
		begin
			col_sel = ~(8'h01 << c);
			step(2);
		end
		col_sel = 8'h00;
		step(2);
		col_sel = 8'b1010_0110;
		step(2);
		col_sel = 8'hFF;
		step(2);
	endtask

	function automatic logic [7:0] random_code();
		logic [7:0] b;
		b = 8'($urandom);
		while (b == CODE_EXTENDED || b == CODE_BREAK)
			b = 8'($urandom);
		return b;
	endfunction

	////////////////////////////////////////
	// Run watchdog
	////////////////////////////////////////

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		plain_fail("simulation timed out before all tests finished");
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h8b98));
		clk          = 1'b0;
		rst_n        = 1'b0;
		ps2_clk      = 1'b1;
		ps2_data     = 1'b1;
		col_sel      = 8'hFF;
		expect_event = 1'b0;
		expect_ferr  = 1'b0;
		exp_key      = '0;
		step(4);
		rst_n = 1'b1;
		step(10);

		// Plain bytes, clean and with clock spikes
		for (int i = 0; i < 6; i++)
			send_key(0, 0, random_code(), 0);
		for (int i = 0; i < 6; i++)
			send_key(0, 0, random_code(), 1);

		// Prefix folding
		send_key(0, 1, random_code(), 0);
		send_key(1, 0, random_code(), 0);
		send_key(1, 1, random_code(), 0);
		send_key(1, 1, 8'h75, 1);

		// Bad frames drop a pending break
		error_frame(1, 0, 0);
		error_frame(0, 1, 0);
		error_frame(0, 0, 1);

		// Partial frame left to time out
		send_frame(8'h2D, 0, 0, 0, 4, 0);
		step(WATCHDOG_CYCLES + 100);
		send_key(0, 0, 8'h2D, 0);

		// Matrix scans
		send_key(0, 0, 8'h1B, 0);
		send_key(0, 0, 8'h29, 0);
		send_key(0, 0, 8'h5A, 0);
		send_key(0, 0, 8'h12, 0);
		send_key(1, 0, 8'h74, 0);
		send_key(1, 0, 8'h72, 0);
		send_key(0, 0, 8'h16, 0);
		scan_all();
		send_key(0, 1, 8'h1C, 0);
		send_key(1, 1, 8'h74, 0);
		scan_all();
		// Unmapped codes, plain and extended
		send_key(0, 0, 8'h05, 0);
		send_key(1, 0, 8'h7D, 0);
		scan_all();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== filelist.f ====
common/kbd_pkg.sv
ps2/ps2_receiver.sv
ps2/ps2_scancode_decoder.sv
hw/key_matrix.sv
hw/kbd_top.sv
test/kbd_assert.sv
test/tb_kbd.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_kbd -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_kbd > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

exit 0
